//--- sim/dbg_cases.txt
# write flag, word address, write data (all hex), frame length (decimal)
# expected 34-bit response (hex): read data << 2, bit 1 length error, bit 0 bus error
1 010 deadbeef 45 000000000
0 010 00000000 45 37ab6fbbc
0 3ff 00000000 45 000000000
1 400 12345678 45 000000001
0 000 00000000 45 000000000
0 800 00000000 45 000000001
1 010 cafef00d 44 000000002
1 010 cafef00d 46 000000002
0 010 00000000 45 37ab6fbbc
1 1a3 0badf00d 45 000000000
1 07c 13579bdf 45 000000000
1 2e5 a5a5a5a5 45 000000000
1 391 00000001 45 000000000
1 0f0 ffffffff 45 000000000
0 1a3 00000000 45 02eb7c034
0 07c 00000000 45 04d5e6f7c
0 2e5 00000000 45 296969694
0 391 00000000 45 000000004
0 0f0 00000000 45 3fffffffc
0 c10 00000000 45 000000001

//--- flist.f
verilog/dbg_pkg.sv
verilog/dbg_cmd_if.sv
verilog/ahb_lite_if.sv
verilog/dbg_shift_in.sv
verilog/ahb_cmd_master.sv
verilog/ahb_sram.sv
verilog/dbg_shift_out.sv
verilog/dbg_top.sv
sim/dbg_top_chk.sv
sim/dbg_top_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module dbg_top_tb -Mdir obj_dir
	out=$$(./obj_dir/Vdbg_top_tb); echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

//--- sim/dbg_top_tb.sv
`timescale 1ns/1ns

module dbg_top_tb;
    import dbg_pkg::*;

    localparam int MAX_CASES    = 64;
    localparam int CLK_PERIOD   = 20;
    localparam int FRAME_CYCLES = 61;  // Longest frame plus the longest gap

    logic clk;
    logic reset;
    logic tms;
    logic tdi;
    logic tdo;

    // Case table as read from the file
    logic                 c_write [MAX_CASES];
    logic [ADDR_BITS-1:0] c_addr  [MAX_CASES];
    logic [DATA_BITS-1:0] c_data  [MAX_CASES];
    int                   c_len   [MAX_CASES];
    logic [RSP_BITS-1:0]  c_rsp   [MAX_CASES];
    logic [RSP_BITS-1:0]  m_rsp   [MAX_CASES];  // Response from the reference model
    int                   n_cases;
    logic                 cases_loaded;

    logic [DATA_BITS-1:0] ref_mem [RAM_WORDS];
    int                   checks;
    int                   errors;

    dbg_top uut (
        .clk   (clk),
        .reset (reset),
        .tms   (tms),
        .tdi   (tdi),
        .tdo   (tdo)
    );

    always #(CLK_PERIOD / 2) clk = !clk;

    task automatic check_value(input string what, input logic [RSP_BITS-1:0] got,
                               input logic [RSP_BITS-1:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERR %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic load_cases();
        int                   fd;
        string                line;
        logic                 wr;
        logic [ADDR_BITS-1:0] addr;
        logic [DATA_BITS-1:0] data;
        int                   len;
        logic [RSP_BITS-1:0]  rsp;
        fd = $fopen("sim/dbg_cases.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the case file sim/dbg_cases.txt");
            return;
        end
        while (!$feof(fd) && n_cases < MAX_CASES)
        begin
            line = "";
            void'($fgets(line, fd));
            // Comment and blank lines do not scan as five fields
            if ($sscanf(line, "%h %h %h %d %h", wr, addr, data, len, rsp) == 5)
            begin
                c_write[n_cases] = wr;
                c_addr[n_cases]  = addr;
                c_data[n_cases]  = data;
                c_len[n_cases]   = len;
                c_rsp[n_cases]   = rsp;
                n_cases++;
            end
        end
        $fclose(fd);
    endtask

    // Expected response by the frame rules and the reference memory
    task automatic model_case(input int idx, output logic [RSP_BITS-1:0] rsp);
        if (c_len[idx] != FRAME_BITS)
            rsp = RSP_BITS'(2);
        else if (c_addr[idx] >= RAM_WORDS)
            rsp = RSP_BITS'(1);
        else if (c_write[idx])
        begin
            ref_mem[c_addr[idx][RAM_ABITS-1:0]] = c_data[idx];
            rsp = '0;
        end
        else
            rsp = {ref_mem[c_addr[idx][RAM_ABITS-1:0]], 2'b00};
    endtask

    // Shifts a frame in on tdi and collects the previous response from tdo
    task automatic send_frame(input logic [47:0] bits, input int len,
                              output logic [RSP_BITS-1:0] prev);
        prev = '0;
        for (int i = 0; i < len; i++)
        begin
            @(posedge clk);
            tms <= 1'b1;
            tdi <= bits[i];
            @(negedge clk);
            if (i < RSP_BITS)
                prev[i] = tdo;  // Shows bit i until the next edge shifts it
        end
        @(posedge clk);
        tms <= 1'b0;
        tdi <= 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    initial
    begin
        longint limit;
        wait (cases_loaded);
        limit = 2 * longint'(n_cases) * FRAME_CYCLES * CLK_PERIOD;
        #(limit);
        $display("Timeout: the run did not finish within %0d ns", limit);
        $display("Checks failed");
        $finish;
    end

    initial
    begin
        logic [RSP_BITS-1:0] got_rsp;
        int                  err_before;
        int                  j;
        clk          = 1'b0;
        reset        = 1'b1;
        tms          = 1'b0;
        tdi          = 1'b0;
        checks       = 0;
        errors       = 0;
        n_cases      = 0;
        cases_loaded = 1'b0;
        for (int i = 0; i < RAM_WORDS; i++)
            ref_mem[i] = '0;  // Matches the cleared SRAM
        void'($urandom(32389));
        load_cases();
        if (n_cases == 0)
        begin
            $display("No cases were read, nothing to run");
            $display("Checks failed");
            $finish;
        end
        else
        begin
            cases_loaded = 1'b1;
            repeat (5) @(posedge clk);
            reset <= 1'b0;
            // One extra dummy frame at the end collects the last response
            for (int i = 0; i <= n_cases; i++)
            begin
                if (i < n_cases)
                begin
                    model_case(i, m_rsp[i]);
                    send_frame({3'b000, c_data[i], c_addr[i], c_write[i]}, c_len[i], got_rsp);
                end
                else
                    send_frame('0, RSP_BITS, got_rsp);
                err_before = errors;
                if (i == 0)
                begin
                    check_value("tdo during first frame after reset", got_rsp, '0);
                    $display("reset: response %h, %s", got_rsp,
                             (errors == err_before) ? "ok" : "mismatch");
                end
                else
                begin
                    j = i - 1;
                    check_value($sformatf("case %0d file word against rules", j),
                                c_rsp[j], m_rsp[j]);
                    check_value($sformatf("case %0d response on tdo", j), got_rsp, m_rsp[j]);
                    $display("case %0d: %s addr %h len %0d, response %h, %s", j,
                             c_write[j] ? "write" : "read", c_addr[j], c_len[j], got_rsp,
                             (errors == err_before) ? "ok" : "mismatch");
                end
                idle_cycles(8 + ($urandom % 8));
            end
            errors = errors + uut.u_master.u_chk.assert_fails;
            $display("%0d cases, %0d checks, %0d errors, %0d assertion failures", n_cases,
                     checks, errors, uut.u_master.u_chk.assert_fails);
            if (errors == 0)
                $display("All checks passed");
            else
                $display("Checks failed");
            $finish;
        end
    end

endmodule

//--- sim/dbg_top_chk.sv
`timescale 1ns/1ns

module dbg_top_chk (
    input logic                           clk,
    input logic                           reset,
    input logic                           cmd_valid,
    input logic [dbg_pkg::DATA_BITS-1:0]  haddr,
    input logic                           hwrite,
    input logic                           hready,
    input logic                           hresp
);

    int assert_fails;

    initial
        assert_fails = 0;

    a_valid_pulse: assert property (@(posedge clk) disable iff (reset)
        cmd_valid |=> !cmd_valid)
        else
        begin
            $error("cmd valid high for two cycles");
            assert_fails++;
        end

    // Address phase held through wait states
    a_addr_hold: assert property (@(posedge clk) disable iff (reset)
        !hready |=> $stable(haddr) && $stable(hwrite))
        else
        begin
            $error("haddr or hwrite changed while hready was low");
            assert_fails++;
        end

    a_err_two_cycle: assert property (@(posedge clk) disable iff (reset)
        (hresp && !hready) |=> (hresp && hready))
        else
        begin
            $error("ERROR response not completed in its second cycle");
            assert_fails++;
        end

endmodule

bind ahb_cmd_master dbg_top_chk u_chk (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd.valid),
    .haddr     (bus.haddr),
    .hwrite    (bus.hwrite),
    .hready    (bus.hready),
    .hresp     (bus.hresp)
);

//--- verilog/dbg_top.sv
`timescale 1ns/1ns

module dbg_top (
    input  logic clk,
    input  logic reset,
    input  logic tms,
    input  logic tdi,
    output logic tdo
);
    import dbg_pkg::*;

    logic                rsp_valid;
    logic [RSP_BITS-1:0] rsp_word;
    logic                frame_err;

    dbg_cmd_if  cmd_bus ();
    ahb_lite_if ahb ();

    dbg_shift_in u_shift_in (
        .clk       (clk),
        .reset     (reset),
        .tms       (tms),
        .tdi       (tdi),
        .cmd       (cmd_bus.src),
        .frame_err (frame_err)
    );

    ahb_cmd_master u_master (
        .clk       (clk),
        .reset     (reset),
        .cmd       (cmd_bus.dst),
        .bus       (ahb.master),
        .rsp_valid (rsp_valid),
        .rsp_word  (rsp_word)
    );

    ahb_sram u_sram (
        .clk   (clk),
        .reset (reset),
        .bus   (ahb.slave)
    );

    dbg_shift_out u_shift_out (
        .clk       (clk),
        .reset     (reset),
        .tms       (tms),
        .rsp_valid (rsp_valid),
        .rsp_word  (rsp_word),
        .frame_err (frame_err),
        .tdo       (tdo)
    );

endmodule

//--- verilog/dbg_shift_out.sv
`timescale 1ns/1ns

module dbg_shift_out (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         tms,
    input  logic                         rsp_valid,
    input  logic [dbg_pkg::RSP_BITS-1:0] rsp_word,
    input  logic                         frame_err,
    output logic                         tdo
);
    import dbg_pkg::*;

    logic [RSP_BITS-1:0] rsp_reg;

    always_ff @(posedge clk)
    begin
        if (reset)
            rsp_reg <= '0;
        else if (rsp_valid)
            rsp_reg <= rsp_word;
        else if (frame_err)
            rsp_reg <= RSP_BITS'(2);  // Only the length error flag
        else if (tms)
            rsp_reg <= {1'b0, rsp_reg[RSP_BITS-1:1]};
    end

    // Bit 0 is visible before the first shift of the frame
    assign tdo = rsp_reg[0];

endmodule

//--- verilog/ahb_sram.sv
`timescale 1ns/1ns

module ahb_sram (
    input  logic      clk,
    input  logic      reset,
    ahb_lite_if.slave bus
);
    import dbg_pkg::*;

    logic [DATA_BITS-1:0] mem [RAM_WORDS];
    logic [DATA_BITS-1:0] rdata;
    logic [RAM_ABITS-1:0] dp_idx;
    logic                 dp_active;
    logic                 dp_second;  // Wait state already spent
    logic                 dp_write;
    logic                 dp_err;
    logic                 addr_err;

    // Contents start cleared, as a RAM init
    initial
    begin
        for (int i = 0; i < RAM_WORDS; i++)
            mem[i] = '0;
    end

    assign addr_err = (bus.haddr[DATA_BITS-1:2] >= (DATA_BITS-2)'(RAM_WORDS))
                   || (bus.hsize != HSIZE_WORD);

    // Reads and errors stall the first data-phase cycle
    assign bus.hready = !(dp_active && !dp_second && (dp_err || !dp_write));
    assign bus.hresp  = (dp_active && dp_err) ? HRESP_ERROR : HRESP_OKAY;
    assign bus.hrdata = rdata;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            dp_active <= 1'b0;
            dp_second <= 1'b0;
        end
        else if (bus.hready)
        begin
            dp_active <= (bus.htrans == HTRANS_NONSEQ);
            dp_second <= 1'b0;
        end
        else
            dp_second <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (bus.hready)
        begin
            dp_idx   <= bus.haddr[RAM_ABITS+1:2];
            dp_write <= bus.hwrite;
            dp_err   <= addr_err;
        end
    end

    always_ff @(posedge clk)
    begin
        if (dp_active && dp_write && !dp_err)
            mem[dp_idx] <= bus.hwdata;
        if (dp_active && !dp_write && !dp_err && !dp_second)
            rdata <= mem[dp_idx];  // Registered output, ready after one wait
    end

endmodule

//--- verilog/ahb_cmd_master.sv
`timescale 1ns/1ns

module ahb_cmd_master (
    input  logic                          clk,
    input  logic                          reset,
    dbg_cmd_if.dst                        cmd,
    ahb_lite_if.master                    bus,
    output logic                          rsp_valid,
    output logic [dbg_pkg::RSP_BITS-1:0]  rsp_word
);
    import dbg_pkg::*;

    logic [1:0]           state;
    logic [DATA_BITS-1:0] addr_q;
    logic                 write_q;
    logic [DATA_BITS-1:0] wdata_q;
    logic [DATA_BITS-1:0] rdata_sel;
    logic                 data_done;

    assign data_done = (state == MST_DATA) && bus.hready;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= MST_IDLE;
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= data_done;
            case (state)
                MST_IDLE:
                    if (cmd.valid)
                        state <= MST_ADDR;
                MST_ADDR:
                    if (bus.hready)  // Address phase accepted
                        state <= MST_DATA;
                MST_DATA:
                    if (bus.hready)
                        state <= MST_IDLE;
                default:
                    state <= MST_IDLE;
            endcase
        end
    end

    // Command fields held for the whole transfer
    always_ff @(posedge clk)
    begin
        if (cmd.valid && state == MST_IDLE)
        begin
            addr_q  <= {{(DATA_BITS-ADDR_BITS-2){1'b0}}, cmd.addr, 2'b00};
            write_q <= cmd.write;
            wdata_q <= cmd.wdata;
        end
    end

    assign bus.htrans = (state == MST_ADDR) ? HTRANS_NONSEQ : HTRANS_IDLE;
    assign bus.haddr  = addr_q;
    assign bus.hwrite = write_q;
    assign bus.hsize  = HSIZE_WORD;
    assign bus.hwdata = wdata_q;

    // Writes and failed transfers return no data
    assign rdata_sel = (write_q || bus.hresp == HRESP_ERROR) ? '0 : bus.hrdata;

    always_ff @(posedge clk)
    begin
        if (data_done)
            rsp_word <= {rdata_sel, 1'b0, bus.hresp};
    end

endmodule

//--- verilog/dbg_shift_in.sv
`timescale 1ns/1ns

module dbg_shift_in (
    input  logic   clk,
    input  logic   reset,
    input  logic   tms,
    input  logic   tdi,
    dbg_cmd_if.src cmd,
    output logic   frame_err
);
    import dbg_pkg::*;

    logic [FRAME_BITS-1:0]     shreg;
    logic [FRAME_CNT_BITS-1:0] count;
    logic                      frame_end;
    logic                      length_ok;

    // Frame ends on the first tms-low sample after at least one bit
    assign frame_end = !tms && (count != '0);
    assign length_ok = (count == FRAME_CNT_BITS'(FRAME_BITS));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count     <= '0;
            cmd.valid <= 1'b0;
            frame_err <= 1'b0;
        end
        else
        begin
            cmd.valid <= 1'b0;
            frame_err <= 1'b0;
            if (tms)
            begin
                if (count <= FRAME_CNT_BITS'(FRAME_BITS))  // Stops one above a full frame
                    count <= count + 1'b1;
            end
            else if (frame_end)
            begin
                cmd.valid <= length_ok;
                frame_err <= !length_ok;
                count     <= '0;
            end
        end
    end

    // LSB first, so the first bit ends up in bit 0
    always_ff @(posedge clk)
    begin
        if (tms)
            shreg <= {tdi, shreg[FRAME_BITS-1:1]};
    end

    // Register is frozen while tms is low, so the fields hold through valid
    assign cmd.write = shreg[0];
    assign cmd.addr  = shreg[ADDR_BITS:1];
    assign cmd.wdata = shreg[FRAME_BITS-1:ADDR_BITS+1];

endmodule

//--- verilog/ahb_lite_if.sv
`timescale 1ns/1ns

interface ahb_lite_if;
    import dbg_pkg::*;

    // Address phase
    logic [DATA_BITS-1:0] haddr;  // Byte address
    logic [1:0]           htrans;
    logic                 hwrite;
    logic [2:0]           hsize;

    // Data phase
    logic [DATA_BITS-1:0] hwdata;
    logic [DATA_BITS-1:0] hrdata;
    logic                 hready;
    logic                 hresp;

    modport master (
        output haddr, htrans, hwrite, hsize, hwdata,
        input  hrdata, hready, hresp
    );

    modport slave (
        input  haddr, htrans, hwrite, hsize, hwdata,
        output hrdata, hready, hresp
    );

endinterface

//--- verilog/dbg_cmd_if.sv
`timescale 1ns/1ns

interface dbg_cmd_if;
    import dbg_pkg::*;

    logic                 valid;  // One-cycle strobe
    logic                 write;
    logic [ADDR_BITS-1:0] addr;   // Word address
    logic [DATA_BITS-1:0] wdata;

    modport src (
        output valid, write, addr, wdata
    );

    modport dst (
        input valid, write, addr, wdata
    );

endinterface

//--- verilog/dbg_pkg.sv
package dbg_pkg;

    // Command frame and memory geometry
    localparam int ADDR_BITS      = 12;
    localparam int DATA_BITS      = 32;
    localparam int FRAME_BITS     = 45;  // write flag + address + data
    localparam int RSP_BITS       = 34;  // bus error, frame error, read data
    localparam int RAM_WORDS      = 1024;
    localparam int RAM_ABITS      = $clog2(RAM_WORDS);
    localparam int FRAME_CNT_BITS = $clog2(FRAME_BITS + 2);

    // AHB-Lite codes
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic       HRESP_OKAY    = 1'b0;
    localparam logic       HRESP_ERROR   = 1'b1;
    localparam logic [2:0] HSIZE_WORD    = 3'b010;

    // Master sequencer states
    localparam logic [1:0] MST_IDLE = 2'd0;
    localparam logic [1:0] MST_ADDR = 2'd1;
    localparam logic [1:0] MST_DATA = 2'd2;

endpackage
